/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := key_recorder_tb
FILE_LIST := list.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# exit status of the simulator is the verdict
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
rtl/key_recorder_pkg.sv
rtl/debounce.sv
rtl/key_memory.sv
rtl/recorder_fsm.sv
rtl/key_recorder_top.sv
testbench/key_recorder_props.sv
testbench/key_recorder_tb.sv

/* rtl/debounce.sv */
`timescale 1ns/10ps

// turns one bouncing input into a clean level
module debounce import key_recorder_pkg::*; (
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // last level seen on the input
  logic sampled;
  // cycles the input has been stable at the sampled level
  debounce_count_t count;

  always_ff @(posedge clock) begin
    if (reset) begin
      // start out agreeing with whatever the input shows
      sampled <= noisy;
      clean <= noisy;
      count <= '0;
    end else if (noisy != sampled) begin
      // input moved, start the stable interval over
      sampled <= noisy;
      count <= '0;
    end else if (count == debounce_count_t'(DEBOUNCE_CYCLES)) begin
      // stable long enough, let it through
      // counter parks here until the next change
      clean <= sampled;
    end else begin
      // still waiting out the interval
      count <= count + 1'b1;
    end
  end

  // a change that reverts before the count ends
  // just restarts the count and never reaches clean
  // total latency is DEBOUNCE_CYCLES + 1 after the last edge

endmodule

/* rtl/key_memory.sv */
`timescale 1ns/10ps

// on-chip store for recorded key words
// single port, registered read, inferred as block ram
module key_memory import key_recorder_pkg::*; (
  input  logic      clock,
  input  logic      write,
  input  mem_addr_t address,
  input  key_word_t write_data,
  output key_word_t read_data
);

  // storage array
  key_word_t mem [MEM_DEPTH];

  always_ff @(posedge clock) begin
    // write lands at this edge
    if (write) begin
      mem[address] <= write_data;
    end
    // read data shows up one cycle after the address
    // (old contents when reading and writing the same word)
    read_data <= mem[address];
  end

endmodule

/* rtl/key_recorder_pkg.sv */
package key_recorder_pkg;

  //////////////////////////////////////////////////////////////////////
  // key word
  //////////////////////////////////////////////////////////////////////

  // one line per key
  localparam int KEY_WIDTH = 17;

  // snapshot of every key line taken at one sample strobe
  typedef logic [KEY_WIDTH-1:0] key_word_t;

  //////////////////////////////////////////////////////////////////////
  // recording memory
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_WIDTH = 4;
  localparam int MEM_DEPTH = 1 << ADDR_WIDTH;

  typedef logic [ADDR_WIDTH-1:0] mem_addr_t;

  // one extra bit so a full memory (16 entries) can be counted
  typedef logic [ADDR_WIDTH:0] rec_length_t;

  //////////////////////////////////////////////////////////////////////
  // debounce
  //////////////////////////////////////////////////////////////////////

  // short interval for simulation, a 27 MHz board needs about 270000
  localparam int DEBOUNCE_CYCLES = 16;

  // must be able to hold DEBOUNCE_CYCLES itself
  typedef logic [4:0] debounce_count_t;

  // recorder operating mode
  typedef enum logic [1:0] {
    MODE_USER,
    MODE_RECORD,
    MODE_PLAYBACK
  } recorder_mode_t;

endpackage

/* rtl/key_recorder_top.sv */
`timescale 1ns/10ps

// key pattern recorder
// debounced keys and buttons feed the recorder, which owns the memory
module key_recorder_top import key_recorder_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           sample_ready,
  input  logic           record_button,
  input  logic           playback_button,
  input  key_word_t      key_lines,
  output key_word_t      key_out,
  output recorder_mode_t mode
);

  // clean versions of the inputs
  key_word_t clean_keys;
  logic clean_record;
  logic clean_playback;

  // memory port
  logic mem_write;
  mem_addr_t mem_address;
  key_word_t mem_write_data;
  key_word_t mem_read_data;

  //////////////////////////////////////////////////////////////////////
  // input debounce
  //////////////////////////////////////////////////////////////////////

  // one filter per key line
  for (genvar i = 0; i < KEY_WIDTH; i++) begin : g_key_debounce
    debounce key_debounce (
      .clock (clock),
      .reset (reset),
      .noisy (key_lines[i]),
      .clean (clean_keys[i])
    );
  end

  debounce record_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (record_button),
    .clean (clean_record)
  );

  debounce playback_debounce (
    .clock (clock),
    .reset (reset),
    .noisy (playback_button),
    .clean (clean_playback)
  );

  //////////////////////////////////////////////////////////////////////
  // recorder and its memory
  //////////////////////////////////////////////////////////////////////

  recorder_fsm recorder (
    .clock          (clock),
    .reset          (reset),
    .sample_ready   (sample_ready),
    .record         (clean_record),
    .playback       (clean_playback),
    .keys           (clean_keys),
    .mem_read_data  (mem_read_data),
    .mem_write      (mem_write),
    .mem_address    (mem_address),
    .mem_write_data (mem_write_data),
    .key_out        (key_out),
    .mode           (mode)
  );

  key_memory memory (
    .clock      (clock),
    .write      (mem_write),
    .address    (mem_address),
    .write_data (mem_write_data),
    .read_data  (mem_read_data)
  );

endmodule

/* rtl/recorder_fsm.sv */
`timescale 1ns/10ps

// three-mode key recorder
// user passes live keys, record stores one word per strobe,
// playback replays the stored words one per strobe
module recorder_fsm import key_recorder_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           sample_ready,
  input  logic           record,
  input  logic           playback,
  input  key_word_t      keys,
  input  key_word_t      mem_read_data,
  output logic           mem_write,
  output mem_addr_t      mem_address,
  output key_word_t      mem_write_data,
  output key_word_t      key_out,
  output recorder_mode_t mode
);

  //////////////////////////////////////////////////////////////////////
  // counters and edge detect
  //////////////////////////////////////////////////////////////////////

  // entry pointer, one bit wider than the memory address
  rec_length_t address;
  // number of words in the last recording
  rec_length_t length;
  // record level at the previous strobe
  logic record_prev;

  logic record_rise;
  rec_length_t address_next;
  logic record_full;

  // press detect is relative to the last strobe, not the last clock
  assign record_rise = record & ~record_prev;
  assign address_next = address + 1'b1;
  // this write fills the last word
  assign record_full = (address_next == rec_length_t'(MEM_DEPTH));

  //////////////////////////////////////////////////////////////////////
  // mode machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      mode <= MODE_USER;
      address <= '0;
      length <= '0;
      record_prev <= 1'b0;
      key_out <= '0;
      mem_write <= 1'b0;
      mem_address <= '0;
    end else begin
      // write strobe lasts exactly one cycle
      mem_write <= 1'b0;

      // everything else holds between strobes
      if (sample_ready) begin
        record_prev <= record;

        case (mode)
          MODE_USER: begin
            // live keys straight through
            key_out <= keys;
            if (record_rise) begin
              mode <= MODE_RECORD;
              address <= '0;
              mem_address <= '0;
            end else if (playback) begin
              mode <= MODE_PLAYBACK;
              address <= '0;
              // first word is read ahead of the next strobe
              mem_address <= '0;
            end
          end

          MODE_RECORD: begin
            if (record_rise) begin
              // second press ends the recording, nothing stored
              mode <= MODE_USER;
            end else if (playback) begin
              mode <= MODE_PLAYBACK;
              address <= '0;
              mem_address <= '0;
            end else begin
              // store this strobe's keys and echo them
              mem_write <= 1'b1;
              mem_address <= address[ADDR_WIDTH-1:0];
              key_out <= keys;
              address <= address_next;
              length <= address_next;
              // memory full, back to user
              if (record_full) begin
                mode <= MODE_USER;
              end
            end
          end

          MODE_PLAYBACK: begin
            if (address == length) begin
              // all words replayed, key_out holds the last one
              mode <= MODE_USER;
            end else if (record_rise) begin
              // length stays until the new recording overwrites it
              mode <= MODE_RECORD;
              address <= '0;
              mem_address <= '0;
            end else begin
              // read data for this address is ready by now
              // since strobes are at least two cycles apart
              key_out <= mem_read_data;
              address <= address_next;
              mem_address <= address_next[ADDR_WIDTH-1:0];
            end
          end

          default: begin
            mode <= MODE_USER;
          end
        endcase
      end
    end
  end

  // write payload, only meaningful while mem_write is high
  always_ff @(posedge clock) begin
    if (sample_ready) begin
      mem_write_data <= keys;
    end
  end

endmodule

/* testbench/key_recorder_props.sv */
`timescale 1ns/10ps

// control checks bound into recorder_fsm
module key_recorder_props import key_recorder_pkg::*; (
  input logic           clock,
  input logic           reset,
  input logic           sample_ready,
  input logic           mem_write,
  input recorder_mode_t mode,
  input key_word_t      key_out
);

  // the write was decided at a strobe seen in record mode
  // (mode may already be back in user when the memory fills)
  write_in_record: assert property (@(posedge clock) disable iff (reset)
    mem_write |-> $past(mode) == MODE_RECORD)
    else $error("mem_write high without a record-mode strobe");

  // write pulse only in the cycle after a strobe
  write_after_strobe: assert property (@(posedge clock) disable iff (reset)
    mem_write |-> $past(sample_ready))
    else $error("mem_write high without a preceding strobe");

  // no encoding outside the three modes
  mode_legal: assert property (@(posedge clock) disable iff (reset)
    (mode == MODE_USER) || (mode == MODE_RECORD) || (mode == MODE_PLAYBACK))
    else $error("mode holds an illegal encoding");

  // output word moves only on strobes
  key_out_on_strobe: assert property (@(posedge clock) disable iff (reset)
    !$stable(key_out) |-> $past(sample_ready))
    else $error("key_out changed without a strobe");

endmodule

bind recorder_fsm key_recorder_props props (
  .clock        (clock),
  .reset        (reset),
  .sample_ready (sample_ready),
  .mem_write    (mem_write),
  .mode         (mode),
  .key_out      (key_out)
);

/* testbench/key_recorder_tb.sv */
`timescale 1ns/10ps

module key_recorder_tb import key_recorder_pkg::*; ();

  localparam int RESET_CYCLES = 3;
  localparam int STROBE_SPACING = 4;
  // longer than the debounce latency of DEBOUNCE_CYCLES + 1
  localparam int SETTLE_CYCLES = DEBOUNCE_CYCLES + 4;
  // pulse that must be filtered out
  localparam int GLITCH_CYCLES = DEBOUNCE_CYCLES / 2;
  localparam int MODE_TIMEOUT = 8;
  localparam int ROW_MAX = 96;

  logic clock = 1'b0;
  logic reset;
  logic sample_ready;
  logic record_button;
  logic playback_button;
  key_word_t key_lines;
  key_word_t key_out;
  recorder_mode_t mode;

  // one stimulus step, expected values hold after its last strobe
  typedef struct {
    key_word_t      keys;
    logic           record;
    logic           playback;
    logic           glitch;
    int             hold;
    recorder_mode_t exp_mode;
    key_word_t      exp_key;
  } row_t;

  row_t table_rows [ROW_MAX];
  int row_count = 0;

  // reference model state, clean levels as the recorder sees them
  recorder_mode_t model_mode = MODE_USER;
  key_word_t model_key = '0;
  key_word_t model_mem [MEM_DEPTH];
  int model_addr = 0;
  int model_length = 0;
  logic model_rec_prev = 1'b0;
  key_word_t model_keys = '0;
  logic model_rec = 1'b0;
  logic model_play = 1'b0;

  key_recorder_top UUT (
    .clock           (clock),
    .reset           (reset),
    .sample_ready    (sample_ready),
    .record_button   (record_button),
    .playback_button (playback_button),
    .key_lines       (key_lines),
    .key_out         (key_out),
    .mode            (mode)
  );

  always #2 clock = ~clock;

  //////////////////////////////////////////////////////////////////////
  // reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_mode(input string name, input recorder_mode_t expected,
                            input recorder_mode_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %s got %s", $time, name,
               expected.name(), actual.name());
      report_failure("mode mismatch");
    end
  endtask

  task automatic check_key(input string name, input key_word_t expected,
                           input key_word_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
      report_failure("key word mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and table
  //////////////////////////////////////////////////////////////////////

  // one strobe of the recorder rules
  task automatic model_strobe();
    logic rise;
    rise = model_rec && !model_rec_prev;
    model_rec_prev = model_rec;
    case (model_mode)
      MODE_USER: begin
        model_key = model_keys;
        if (rise) begin
          model_mode = MODE_RECORD;
          model_addr = 0;
        end else if (model_play) begin
          model_mode = MODE_PLAYBACK;
          model_addr = 0;
        end
      end
      MODE_RECORD: begin
        if (rise) begin
          model_mode = MODE_USER;
        end else if (model_play) begin
          model_mode = MODE_PLAYBACK;
          model_addr = 0;
        end else begin
          model_mem[mem_addr_t'(model_addr)] = model_keys;
          model_key = model_keys;
          model_addr = model_addr + 1;
          model_length = model_addr;
          if (model_addr == MEM_DEPTH) model_mode = MODE_USER;
        end
      end
      default: begin
        if (model_addr == model_length) begin
          model_mode = MODE_USER;
        end else if (rise) begin
          model_mode = MODE_RECORD;
          model_addr = 0;
        end else begin
          model_key = model_mem[mem_addr_t'(model_addr)];
          model_addr = model_addr + 1;
        end
      end
    endcase
  endtask

  // glitch rows pulse the keys briefly, so clean levels stay put
  // a glitch row takes a single strobe inside its pulse
  task automatic add_row(input key_word_t keys, input logic rec, input logic play,
                         input logic glitch, input int hold);
    if (row_count >= ROW_MAX) report_failure("stimulus table is full");
    if (!glitch) begin
      model_keys = keys;
      model_rec = rec;
      model_play = play;
    end
    repeat (hold) model_strobe();
    table_rows[row_count].keys = keys;
    table_rows[row_count].record = model_rec;
    table_rows[row_count].playback = model_play;
    table_rows[row_count].glitch = glitch;
    table_rows[row_count].hold = hold;
    table_rows[row_count].exp_mode = model_mode;
    table_rows[row_count].exp_key = model_key;
    row_count++;
  endtask

  function automatic key_word_t random_key();
    return key_word_t'($urandom());
  endfunction

  task automatic build_table();
    key_word_t k;
    // reset and live keys, then a filtered glitch and a held change
    add_row(17'h0a5c3, 1'b0, 1'b0, 1'b0, 2);
    add_row(17'h1f00f, 1'b0, 1'b0, 1'b1, 1);
    k = 17'h15a3c;
    add_row(k, 1'b0, 1'b0, 1'b0, 1);
    // six words, closed by a second record press
    add_row(k, 1'b1, 1'b0, 1'b0, 1);
    for (int i = 0; i < 6; i++) begin
      k = random_key();
      add_row(k, 1'b0, 1'b0, 1'b0, 1);
    end
    add_row(k, 1'b1, 1'b0, 1'b0, 1);
    add_row(k, 1'b0, 1'b0, 1'b0, 1);
    // replay them, the seventh strobe returns to user
    add_row(k, 1'b0, 1'b1, 1'b0, 1);
    for (int i = 0; i < 7; i++) add_row(k, 1'b0, 1'b0, 1'b0, 1);
    // fill all sixteen words, extra strobes land in user
    add_row(k, 1'b1, 1'b0, 1'b0, 1);
    for (int i = 0; i < MEM_DEPTH; i++) add_row(random_key(), 1'b0, 1'b0, 1'b0, 1);
    k = random_key();
    add_row(k, 1'b0, 1'b0, 1'b0, 3);
    add_row(k, 1'b0, 1'b1, 1'b0, 1);
    for (int i = 0; i <= MEM_DEPTH; i++) add_row(k, 1'b0, 1'b0, 1'b0, 1);
    // interrupt a replay with a record press, record three new words
    add_row(k, 1'b0, 1'b1, 1'b0, 1);
    add_row(k, 1'b0, 1'b0, 1'b0, 2);
    add_row(k, 1'b1, 1'b0, 1'b0, 1);
    for (int i = 0; i < 3; i++) begin
      k = random_key();
      add_row(k, 1'b0, 1'b0, 1'b0, 1);
    end
    add_row(k, 1'b1, 1'b0, 1'b0, 1);
    add_row(k, 1'b0, 1'b0, 1'b0, 1);
    add_row(k, 1'b0, 1'b1, 1'b0, 1);
    for (int i = 0; i < 4; i++) add_row(k, 1'b0, 1'b0, 1'b0, 1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and wait
  //////////////////////////////////////////////////////////////////////

  // one-cycle pulse, then idle up to the next strobe slot
  task automatic send_strobe();
    sample_ready = 1'b1;
    @(negedge clock);
    sample_ready = 1'b0;
    repeat (STROBE_SPACING - 1) @(negedge clock);
  endtask

  // strobe in the last cycle of a short key pulse
  // an unfiltered pulse would be captured on key_out here
  task automatic strobe_during_glitch(input key_word_t glitch_keys,
                                      input key_word_t held_keys);
    key_lines = glitch_keys;
    repeat (GLITCH_CYCLES - 1) @(negedge clock);
    sample_ready = 1'b1;
    @(negedge clock);
    sample_ready = 1'b0;
    key_lines = held_keys;
    repeat (SETTLE_CYCLES) @(negedge clock);
  endtask

  task automatic wait_for_mode(input recorder_mode_t expected);
    int waited;
    waited = 0;
    while (mode !== expected && waited < MODE_TIMEOUT) begin
      @(negedge clock);
      waited++;
    end
    if (mode !== expected) begin
      $display("timeout at %0t: mode never changed to %s", $time, expected.name());
      report_failure("timeout waiting for a mode change");
    end
  endtask

  initial begin
    void'($urandom(32'hbbe5));
    reset = 1'b1;
    sample_ready = 1'b0;
    record_button = 1'b0;
    playback_button = 1'b0;
    key_lines = '0;
    build_table();
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    check_mode("mode", MODE_USER, mode);
    check_key("key_out", '0, key_out);

    for (int r = 0; r < row_count; r++) begin
      if (table_rows[r].glitch) begin
        strobe_during_glitch(table_rows[r].keys, keys_before_glitch(r));
      end else begin
        if (table_rows[r].keys !== key_lines ||
            table_rows[r].record !== record_button ||
            table_rows[r].playback !== playback_button) begin
          key_lines = table_rows[r].keys;
          record_button = table_rows[r].record;
          playback_button = table_rows[r].playback;
          repeat (SETTLE_CYCLES) @(negedge clock);
        end
        repeat (table_rows[r].hold) send_strobe();
      end
      // wait out an expected mode change, else compare the held mode
      if (r > 0 && table_rows[r].exp_mode != table_rows[r-1].exp_mode) begin
        wait_for_mode(table_rows[r].exp_mode);
      end else begin
        check_mode("mode", table_rows[r].exp_mode, mode);
      end
      check_key("key_out", table_rows[r].exp_key, key_out);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // key word held before a glitch row, restored once the pulse ends
  function automatic key_word_t keys_before_glitch(input int r);
    for (int i = r - 1; i >= 0; i--) begin
      if (!table_rows[i].glitch) return table_rows[i].keys;
    end
    return '0;
  endfunction

endmodule
